// File: rtl/arcade_shell_pkg.sv
/*
 * shared definitions for the arcade board glue
 * vector typedefs, bridge register addresses, key bit positions,
 * reset hold count, input/config/video structs and the timer enum
 */

`default_nettype none

package arcade_shell_pkg;

    ////////////////////
    // vector types

    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;
    typedef logic [15:0] key_word_t;
    typedef logic [7:0]  dip_t;
    typedef logic [3:0]  mode_t;
    // core pixel, blue in the top nibble
    typedef logic [11:0] rgb444_t;
    // scaler pixel, red in the top byte
    typedef logic [23:0] rgb888_t;
    typedef logic [13:0] hold_count_t;

    ////////////////////
    // constants

    // bridge register window
    localparam bridge_addr_t addr_reset = 32'hF000_0000;
    localparam bridge_addr_t addr_dip   = 32'hF100_0000;
    localparam bridge_addr_t addr_mode  = 32'hF200_0000;

    // core stays in reset this long after a restart
    localparam hold_count_t reset_hold_cycles = 14'd8000;

    // bit positions in the controller key bitmap
    localparam int key_up     = 0;
    localparam int key_down   = 1;
    localparam int key_left   = 2;
    localparam int key_right  = 3;
    localparam int key_a      = 4;
    localparam int key_b      = 5;
    localparam int key_x      = 6;
    localparam int key_y      = 7;
    localparam int key_select = 14;
    localparam int key_start  = 15;

    ////////////////////
    // structs

    // one player word as the core samples it
    typedef struct packed {
        logic fire2;
        logic fire1;
        logic left;
        logic down;
        logic right;
        logic up;
    } player_inp_t;

    typedef struct packed {
        logic p2_coin;
        logic p1_coin;
        logic p2_start;
        logic p1_start;
    } system_inp_t;

    // dip banks and title select for the core
    typedef struct packed {
        dip_t  dsw0;
        dip_t  dsw1;
        dip_t  dsw2;
        mode_t mode;
    } core_cfg_t;

    typedef struct packed {
        rgb444_t rgb;
        logic    hs;
        logic    vs;
        logic    de;
    } video_px_t;

    typedef struct packed {
        rgb888_t rgb;
        logic    hs;
        logic    vs;
        logic    de;
    } video_out_t;

    typedef enum logic {
        rst_hold,
        rst_run
    } reset_state_t;

endpackage

`default_nettype wire

// File: rtl/arcade_shell_top.sv
/*
 * board-side glue top level
 * bridge registers, core reset timer, input map and video expander
 */

`default_nettype none

module arcade_shell_top (
    input  logic                           clk_74a,
    input  logic                           temp_reset,

    // host bridge, synchronous to clk_74a
    input  arcade_shell_pkg::bridge_addr_t bridge_addr,
    input  logic                           bridge_rd,
    input  logic                           bridge_wr,
    input  arcade_shell_pkg::bridge_data_t bridge_wr_data,
    output arcade_shell_pkg::bridge_data_t bridge_rd_data,

    // controller key bitmaps
    input  arcade_shell_pkg::key_word_t    cont1_key,
    input  arcade_shell_pkg::key_word_t    cont2_key,

    // pixel from the core
    input  arcade_shell_pkg::video_px_t    core_px,

    // toward the core
    output arcade_shell_pkg::core_cfg_t    cfg,
    output logic                           core_reset,
    output arcade_shell_pkg::player_inp_t  p1_inp,
    output arcade_shell_pkg::player_inp_t  p2_inp,
    output arcade_shell_pkg::system_inp_t  sys_inp,

    // toward the scaler
    output arcade_shell_pkg::video_out_t   video_out
);

    // restart strobe from the register block to the timer
    logic restart_pulse;

    ////////////////////
    // host side

    bridge_cfg_regs u_regs (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .core_reset     (core_reset),
        .bridge_rd_data (bridge_rd_data),
        .cfg            (cfg),
        .restart_pulse  (restart_pulse)
    );

    core_reset_timer u_rst_timer (
        .clk_74a       (clk_74a),
        .temp_reset    (temp_reset),
        .restart_pulse (restart_pulse),
        .core_reset    (core_reset)
    );

    ////////////////////
    // inputs and video

    cabinet_input_map u_inputs (
        .clk_74a    (clk_74a),
        .temp_reset (temp_reset),
        .p1_keys    (cont1_key),
        .p2_keys    (cont2_key),
        .p1_inp     (p1_inp),
        .p2_inp     (p2_inp),
        .sys_inp    (sys_inp)
    );

    rgb444_expand u_video (
        .clk_74a    (clk_74a),
        .temp_reset (temp_reset),
        .px_in      (core_px),
        .px_out     (video_out)
    );

endmodule

`default_nettype wire

// File: rtl/bridge_cfg_regs.sv
/*
 * host bridge register block
 * restart, dip word and mode registers, restart pulse,
 * registered read buffer with address-windowed read mux
 */

`default_nettype none

module bridge_cfg_regs (
    input  logic                          clk_74a,
    input  logic                          temp_reset,
    input  arcade_shell_pkg::bridge_addr_t bridge_addr,
    input  logic                          bridge_rd,
    input  logic                          bridge_wr,
    input  arcade_shell_pkg::bridge_data_t bridge_wr_data,
    input  logic                          core_reset,
    output arcade_shell_pkg::bridge_data_t bridge_rd_data,
    output arcade_shell_pkg::core_cfg_t    cfg,
    output logic                          restart_pulse
);

    import arcade_shell_pkg::*;

    // address decode
    logic hit_reset;
    logic hit_dip;
    logic hit_mode;

    bridge_data_t dip_word;
    mode_t        mode_reg;
    bridge_data_t rd_buf;

    assign hit_reset = (bridge_addr == addr_reset);
    assign hit_dip   = (bridge_addr == addr_dip);
    assign hit_mode  = (bridge_addr == addr_mode);

    ////////////////////
    // write side

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            dip_word      <= '0;
            mode_reg      <= '0;
            restart_pulse <= 1'b0;
        end else begin
            // single cycle, dip writes restart too
            restart_pulse <= bridge_wr && (hit_reset || hit_dip);
            if (bridge_wr && hit_dip) begin
                dip_word <= bridge_wr_data;
            end
            // only the low nibble is kept
            if (bridge_wr && hit_mode) begin
                mode_reg <= bridge_wr_data[3:0];
            end
        end
    end

    // bank split as the core numbers them
    assign cfg.dsw2 = dip_word[7:0];
    assign cfg.dsw0 = dip_word[15:8];
    assign cfg.dsw1 = dip_word[23:16];
    assign cfg.mode = mode_reg;

    ////////////////////
    // read side

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            rd_buf <= '0;
        end else if (bridge_rd) begin
            if (hit_reset) begin
                rd_buf <= {31'b0, core_reset};
            end else if (hit_dip) begin
                rd_buf <= dip_word;
            end else if (hit_mode) begin
                rd_buf <= {28'b0, mode_reg};
            end
        end
    end

    // buffer only visible while the host holds a window address
    always_comb begin
        if (hit_reset || hit_dip || hit_mode) begin
            bridge_rd_data = rd_buf;
        end else begin
            bridge_rd_data = '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/cabinet_input_map.sv
/*
 * cabinet input mapping
 * controller key bitmaps to registered player and coin/start words
 */

`default_nettype none

module cabinet_input_map (
    input  logic                          clk_74a,
    input  logic                          temp_reset,
    input  arcade_shell_pkg::key_word_t   p1_keys,
    input  arcade_shell_pkg::key_word_t   p2_keys,
    output arcade_shell_pkg::player_inp_t p1_inp,
    output arcade_shell_pkg::player_inp_t p2_inp,
    output arcade_shell_pkg::system_inp_t sys_inp
);

    import arcade_shell_pkg::*;

    // d-pad straight through, face buttons merged in pairs
    function automatic player_inp_t map_player(input key_word_t keys);
        player_inp_t p;
        p.up    = keys[key_up];
        p.down  = keys[key_down];
        p.left  = keys[key_left];
        p.right = keys[key_right];
        // a/b fire1, x/y fire2
        p.fire1 = keys[key_a] | keys[key_b];
        p.fire2 = keys[key_x] | keys[key_y];
        return p;
    endfunction

    system_inp_t sys_next;

    // select acts as coin
    assign sys_next.p1_coin  = p1_keys[key_select];
    assign sys_next.p2_coin  = p2_keys[key_select];
    assign sys_next.p1_start = p1_keys[key_start];
    assign sys_next.p2_start = p2_keys[key_start];

    ////////////////////
    // output stage

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            p1_inp  <= '0;
            p2_inp  <= '0;
            sys_inp <= '0;
        end else begin
            p1_inp  <= map_player(p1_keys);
            p2_inp  <= map_player(p2_keys);
            sys_inp <= sys_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/core_reset_timer.sv
/*
 * core reset hold timer
 * two-state fsm with a down-counter, reloaded on any restart
 */

`default_nettype none

module core_reset_timer (
    input  logic clk_74a,
    input  logic temp_reset,
    input  logic restart_pulse,
    output logic core_reset
);

    import arcade_shell_pkg::*;

    reset_state_t state;
    hold_count_t  hold_cnt;

    always_ff @(posedge clk_74a) begin
        if (temp_reset || restart_pulse) begin
            // restart mid-hold starts the full count again
            state    <= rst_hold;
            hold_cnt <= reset_hold_cycles;
        end else begin
            case (state)
                rst_hold: begin
                    // release one cycle after hitting zero
                    if (hold_cnt == '0) begin
                        state <= rst_run;
                    end else begin
                        hold_cnt <= hold_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= rst_run;
                end
            endcase
        end
    end

    assign core_reset = (state == rst_hold);

endmodule

`default_nettype wire

// File: rtl/rgb444_expand.sv
/*
 * video colour expander
 * rgb444 to rgb888 with channel reorder, sync and de delayed alongside
 */

`default_nettype none

module rgb444_expand (
    input  logic                         clk_74a,
    input  logic                         temp_reset,
    input  arcade_shell_pkg::video_px_t  px_in,
    output arcade_shell_pkg::video_out_t px_out
);

    import arcade_shell_pkg::*;

    rgb888_t rgb_wide;

    // core has red low, scaler wants red high
    // each nibble goes to the top of its byte, low nibble zero
    assign rgb_wide = {px_in.rgb[3:0],  4'h0,
                       px_in.rgb[7:4],  4'h0,
                       px_in.rgb[11:8], 4'h0};

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            px_out <= '0;
        end else begin
            px_out.rgb <= rgb_wide;
            // same stage so sync stays aligned to pixel
            px_out.hs  <= px_in.hs;
            px_out.vs  <= px_in.vs;
            px_out.de  <= px_in.de;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module arcade_shell_tb -o arcade_shell_sim

out=$(./obj_dir/arcade_shell_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi

// File: verification/arcade_shell_tb.sv
/*
 * testbench for the arcade board glue top level
 * clock and reset, bridge read/write tasks, stimulus tables,
 * lfsr pixel source, typed compare tasks and cycle watchdog
 */

`default_nettype none

module arcade_shell_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import arcade_shell_pkg::*;

    // key pair in, expected cabinet words out
    typedef struct packed {
        key_word_t   p1_keys;
        key_word_t   p2_keys;
        player_inp_t exp_p1;
        player_inp_t exp_p2;
        system_inp_t exp_sys;
    } key_row_t;

    // bridge write, expected cfg, read-back and core_reset around it
    typedef struct packed {
        bridge_addr_t addr;
        bridge_data_t data;
        core_cfg_t    exp_cfg;
        bridge_data_t exp_rd;
        logic         rst_mid;
        logic         rst_after;
    } cfg_row_t;

    localparam int n_key    = 12;
    localparam int n_cfg    = 4;
    localparam int n_pixels = 64;
    // release timing of the core reset
    localparam int fall_after_release = 8001;
    localparam int fall_after_write   = 8002;
    localparam int cycle_limit = (n_key + n_cfg) * 4 + 3 * 8010 + 200;

    logic         clk_74a;
    logic         temp_reset;
    bridge_addr_t bridge_addr;
    logic         bridge_rd;
    logic         bridge_wr;
    bridge_data_t bridge_wr_data;
    bridge_data_t bridge_rd_data;
    key_word_t    cont1_key;
    key_word_t    cont2_key;
    video_px_t    core_px;
    core_cfg_t    cfg;
    logic         core_reset;
    player_inp_t  p1_inp;
    player_inp_t  p2_inp;
    system_inp_t  sys_inp;
    video_out_t   video_out;

    key_row_t     key_tab [0:n_key-1];
    cfg_row_t     cfg_tab [0:n_cfg-1];
    logic [31:0]  lfsr_state;
    logic [31:0]  rnd;
    bridge_data_t rd_val;
    int           cycle_cnt = 0;
    int           rel_cycle;
    int           wr_cycle;
    int           fall_cycle;

    arcade_shell_top u_dut (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .cont1_key      (cont1_key),
        .cont2_key      (cont2_key),
        .core_px        (core_px),
        .cfg            (cfg),
        .core_reset     (core_reset),
        .p1_inp         (p1_inp),
        .p2_inp         (p2_inp),
        .sys_inp        (sys_inp),
        .video_out      (video_out)
    );

    ////////////////////
    // clock and watchdog

    initial begin
        clk_74a = 1'b0;
        forever #10 clk_74a = ~clk_74a;
    end

    always @(posedge clk_74a) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run went past %0d clock cycles", cycle_limit);
            $display("RESULT: FAIL");
            $fatal(1, "watchdog expired");
        end
    end

    ////////////////////
    // compare tasks

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("FAIL %s got %h expected %h", name, got, exp);
        $display("RESULT: FAIL");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic check_player(input string name, input player_inp_t got,
                                input player_inp_t exp);
        if (got !== exp) show_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_sys(input string name, input system_inp_t got,
                             input system_inp_t exp);
        if (got !== exp) show_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_cfg(input string name, input core_cfg_t got, input core_cfg_t exp);
        if (got !== exp) show_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_data(input string name, input bridge_data_t got,
                              input bridge_data_t exp);
        if (got !== exp) show_mismatch(name, got, exp);
    endtask

    task automatic check_video(input string name, input video_out_t got,
                               input video_out_t exp);
        if (got !== exp) show_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) show_mismatch(name, 32'(got), 32'(exp));
    endtask

    // cycle distances of the reset timer
    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp) show_mismatch(name, 32'(got), 32'(exp));
    endtask

    ////////////////////
    // stimulus helpers

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // red sits low on the core side, high on the scaler side
    function automatic video_out_t expand_px(input video_px_t px);
        video_out_t o;
        o.rgb[23:16] = {px.rgb[3:0], 4'h0};
        o.rgb[15:8]  = {px.rgb[7:4], 4'h0};
        o.rgb[7:0]   = {px.rgb[11:8], 4'h0};
        o.hs = px.hs;
        o.vs = px.vs;
        o.de = px.de;
        return o;
    endfunction

    // one-cycle write strobe, returns on the falling edge after it
    task automatic write_reg(input bridge_addr_t addr, input bridge_data_t data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk_74a);
        bridge_wr = 1'b0;
    endtask

    // address stays held while the buffer is sampled
    task automatic read_reg(input bridge_addr_t addr, output bridge_data_t data);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        @(negedge clk_74a);
        bridge_rd = 1'b0;
        data = bridge_rd_data;
    endtask

    task automatic wait_reset_low(output int at_cycle);
        while (core_reset !== 1'b0) begin
            @(negedge clk_74a);
        end
        at_cycle = cycle_cnt;
    endtask

    task automatic fill_tables();
        // player word is fire2 fire1 left down right up
        key_tab[0]  = {16'h0000, 16'h0000, 6'b000000, 6'b000000, 4'b0000};
        key_tab[1]  = {16'h0001, 16'h0002, 6'b000001, 6'b000100, 4'b0000};
        key_tab[2]  = {16'h0004, 16'h0008, 6'b001000, 6'b000010, 4'b0000};
        key_tab[3]  = {16'h0010, 16'h0020, 6'b010000, 6'b010000, 4'b0000};
        key_tab[4]  = {16'h0040, 16'h0080, 6'b100000, 6'b100000, 4'b0000};
        key_tab[5]  = {16'h0030, 16'h00C0, 6'b010000, 6'b100000, 4'b0000};
        // system word is p2_coin p1_coin p2_start p1_start
        key_tab[6]  = {16'h4000, 16'h8000, 6'b000000, 6'b000000, 4'b0110};
        key_tab[7]  = {16'h8000, 16'h4000, 6'b000000, 6'b000000, 4'b1001};
        key_tab[8]  = {16'hFFFF, 16'hFFFF, 6'b111111, 6'b111111, 4'b1111};
        // unused bits 13..8 change nothing
        key_tab[9]  = {16'h3F00, 16'h3F00, 6'b000000, 6'b000000, 4'b0000};
        key_tab[10] = {16'hC05A, 16'h0000, 6'b110110, 6'b000000, 4'b0101};
        key_tab[11] = {16'h0000, 16'h00A5, 6'b000000, 6'b111001, 4'b0000};

        // cfg is dsw0 dsw1 dsw2 mode, dip split 15..8, 23..16, 7..0
        cfg_tab[0] = {addr_mode, 32'h0000_0005, 28'h000_0005, 32'h0000_0005, 1'b0, 1'b0};
        cfg_tab[1] = {addr_mode, 32'hFFFF_FFFA, 28'h000_000A, 32'h0000_000A, 1'b0, 1'b0};
        cfg_tab[2] = {addr_dip,  32'h1234_5678, 28'h563_478A, 32'h1234_5678, 1'b0, 1'b1};
        // second dip write lands mid-hold and reloads the count
        cfg_tab[3] = {addr_dip,  32'hA5C3_0FF0, 28'h0FC_3F0A, 32'hA5C3_0FF0, 1'b1, 1'b1};
    endtask

    ////////////////////
    // test sequence

    initial begin
        temp_reset     = 1'b1;
        bridge_addr    = '0;
        bridge_rd      = 1'b0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        // busy inputs during reset, outputs must stay clear
        cont1_key      = 16'hFFFF;
        cont2_key      = 16'hFFFF;
        core_px        = 15'h7FFF;
        lfsr_state     = 32'hc9ae5b86;
        fill_tables();

        repeat (5) @(posedge clk_74a);
        @(negedge clk_74a);
        temp_reset = 1'b0;
        rel_cycle  = cycle_cnt;
        cont1_key  = '0;
        cont2_key  = '0;
        core_px    = '0;
        check_bit("core_reset", core_reset, 1'b1);
        check_player("p1_inp", p1_inp, '0);
        check_player("p2_inp", p2_inp, '0);
        check_sys("sys_inp", sys_inp, '0);
        check_video("video_out", video_out, '0);
        check_cfg("cfg", cfg, '0);

        // shell reset release
        read_reg(addr_reset, rd_val);
        check_data("bridge_rd_data", rd_val, 32'h1);
        wait_reset_low(fall_cycle);
        check_cycles("core_reset release", fall_cycle - rel_cycle, fall_after_release);
        read_reg(addr_reset, rd_val);
        check_data("bridge_rd_data", rd_val, 32'h0);

        // mode and dip writes
        for (int r = 0; r < n_cfg; r++) begin
            write_reg(cfg_tab[r].addr, cfg_tab[r].data);
            wr_cycle = cycle_cnt;
            check_cfg("cfg", cfg, cfg_tab[r].exp_cfg);
            check_bit("core_reset", core_reset, cfg_tab[r].rst_mid);
            read_reg(cfg_tab[r].addr, rd_val);
            check_data("bridge_rd_data", rd_val, cfg_tab[r].exp_rd);
            check_bit("core_reset", core_reset, cfg_tab[r].rst_after);
        end
        wait_reset_low(fall_cycle);
        check_cycles("core_reset after dip", fall_cycle - wr_cycle, fall_after_write);

        // outside the window
        read_reg(32'hF800_0000, rd_val);
        check_data("bridge_rd_data", rd_val, 32'h0);

        // restart only, cfg untouched
        write_reg(addr_reset, 32'hFFFF_FFFF);
        wr_cycle = cycle_cnt;
        check_cfg("cfg", cfg, cfg_tab[n_cfg-1].exp_cfg);
        check_bit("core_reset", core_reset, 1'b0);
        @(negedge clk_74a);
        check_bit("core_reset", core_reset, 1'b1);
        wait_reset_low(fall_cycle);
        check_cycles("core_reset after restart", fall_cycle - wr_cycle, fall_after_write);
        read_reg(addr_reset, rd_val);
        check_data("bridge_rd_data", rd_val, 32'h0);

        // cabinet inputs, one cycle latency
        for (int r = 0; r < n_key; r++) begin
            cont1_key = key_tab[r].p1_keys;
            cont2_key = key_tab[r].p2_keys;
            @(negedge clk_74a);
            check_player("p1_inp", p1_inp, key_tab[r].exp_p1);
            check_player("p2_inp", p2_inp, key_tab[r].exp_p2);
            check_sys("sys_inp", sys_inp, key_tab[r].exp_sys);
        end

        // random pixels with sync and de
        for (int k = 0; k < n_pixels; k++) begin
            take_bits(15, rnd);
            core_px = rnd[14:0];
            @(negedge clk_74a);
            check_video("video_out", video_out, expand_px(core_px));
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/arcade_shell_pkg.sv
rtl/bridge_cfg_regs.sv
rtl/core_reset_timer.sv
rtl/cabinet_input_map.sv
rtl/rgb444_expand.sv
rtl/arcade_shell_top.sv
verification/arcade_shell_tb.sv
